//--- src/crs_pkg.sv
package crs_pkg;

  // register bus and field types
  typedef logic [11:0] crs_adr_t;
  typedef logic [15:0] crs_word_t;
  typedef logic [11:0] trig_thresh_t;
  typedef logic [27:0] pg_addr_t;
  typedef logic [4:0]  chan_sel_t;

  // trigger and waveform buffer configuration
  localparam crs_adr_t ADR_VNUM        = 12'hfff;
  localparam crs_adr_t ADR_TRIG_CTRL   = 12'hffe;
  localparam crs_adr_t ADR_TRIG_THR    = 12'hffd;
  localparam crs_adr_t ADR_TRIG_RUN_LO = 12'hffc;
  localparam crs_adr_t ADR_TRIG_MODE   = 12'hffb;
  localparam crs_adr_t ADR_ARM_LO      = 12'hffa;
  localparam crs_adr_t ADR_ARMED_LO    = 12'hff9;
  localparam crs_adr_t ADR_CNST_RUN    = 12'hff8;
  localparam crs_adr_t ADR_CNST_CONF   = 12'hff7;
  localparam crs_adr_t ADR_TEST_CONF   = 12'hff6;
  localparam crs_adr_t ADR_POST_CONF   = 12'hff5;
  localparam crs_adr_t ADR_PRE_CONF    = 12'hff4;

  // readout and per-channel buffer status
  localparam crs_adr_t ADR_RDOUT_LEN   = 12'heff;
  localparam crs_adr_t ADR_RDOUT_DONE  = 12'hefe;
  localparam crs_adr_t ADR_N_WFMS      = 12'hefc;
  localparam crs_adr_t ADR_WDS_USED    = 12'hefb;
  localparam crs_adr_t ADR_OVERFLOW_LO = 12'hefa;
  localparam crs_adr_t ADR_WVB_RST_LO  = 12'hef9;
  localparam crs_adr_t ADR_STATUS_SEL  = 12'hef5;
  localparam crs_adr_t ADR_TRIG_RUN_HI = 12'hef4;
  localparam crs_adr_t ADR_ARM_HI      = 12'hef3;
  localparam crs_adr_t ADR_ARMED_HI    = 12'hef2;
  localparam crs_adr_t ADR_OVERFLOW_HI = 12'hef1;
  localparam crs_adr_t ADR_WVB_RST_HI  = 12'hef0;

  // memory page requests
  localparam crs_adr_t ADR_PG_ADDR_HI  = 12'hdff;
  localparam crs_adr_t ADR_PG_ADDR_LO  = 12'hdfe;
  localparam crs_adr_t ADR_PG_OPTYPE   = 12'hdfd;
  localparam crs_adr_t ADR_PG_START    = 12'hdfc;
  localparam crs_adr_t ADR_MEM_EN      = 12'hdfb;

  // scratch RAM sits below this address
  localparam crs_adr_t SCRATCH_LIMIT = 12'h800;

  // channels held in the low word of split registers
  localparam int CHAN_LO_W = 16;

endpackage

//--- src/crs_bus_if.sv
`timescale 1ns/1ps

interface crs_bus_if;

  // one-clock strobe per bus cycle
  logic                stb;
  logic                we;
  crs_pkg::crs_adr_t   adr;
  crs_pkg::crs_word_t  wr_data;
  // registered read data, valid the clock after stb
  crs_pkg::crs_word_t  rd_data;

  modport arbiter (
    output stb, we, adr, wr_data,
    input  rd_data
  );

  modport responder (
    input  stb, we, adr, wr_data,
    output rd_data
  );

endinterface

//--- src/crs_arbiter.sv
`timescale 1ns/1ps

module crs_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  logic               a_req,
  input  logic               a_we,
  input  logic               b_req,
  input  logic               b_we,
  input  crs_pkg::crs_adr_t  a_adr,
  input  crs_pkg::crs_adr_t  b_adr,
  input  crs_pkg::crs_word_t a_wr_data,
  input  crs_pkg::crs_word_t b_wr_data,
  output logic               a_ack,
  output logic               b_ack,
  output crs_pkg::crs_word_t a_rd_data,
  output crs_pkg::crs_word_t b_rd_data,
  crs_bus_if.arbiter         bus
);

  typedef enum logic [1:0] {
    st_idle,
    st_strobe,
    st_capture,
    st_ack
  } arb_state_t;

  arb_state_t state;
  // port b served last; set on reset so port a wins first
  logic       sel_b;
  logic       pick_b;
  logic       sel_req;

  assign pick_b  = b_req && (!a_req || !sel_b);
  assign sel_req = sel_b ? b_req : a_req;

  //////////////////////////////////////////////////////////////////////
  // handshake FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      sel_b   <= 1'b1;
      bus.stb <= 1'b0;
      a_ack   <= 1'b0;
      b_ack   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // ack drops one clock after the served host lets go of req
          a_ack <= 1'b0;
          b_ack <= 1'b0;
          if (a_req || b_req) begin
            sel_b <= pick_b;
            state <= st_strobe;
          end
        end
        st_strobe: begin
          bus.stb <= 1'b1;
          state   <= st_capture;
        end
        st_capture: begin
          bus.stb <= 1'b0;
          // responders register on the strobe edge, so wait it out
          if (!bus.stb) begin
            a_ack <= !sel_b;
            b_ack <= sel_b;
            state <= st_ack;
          end
        end
        st_ack: begin
          // hold ack as long as the host holds req
          if (!sel_req) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request and response payload
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      bus.we      <= pick_b ? b_we : a_we;
      bus.adr     <= pick_b ? b_adr : a_adr;
      bus.wr_data <= pick_b ? b_wr_data : a_wr_data;
    end
    if (state == st_capture && !bus.stb) begin
      if (sel_b) begin
        b_rd_data <= bus.rd_data;
      end else begin
        a_rd_data <= bus.rd_data;
      end
    end
  end

endmodule

//--- src/crs_reg_file.sv
`timescale 1ns/1ps

module crs_reg_file #(
  parameter int num_channels = 24
) (
  input  logic                    clk,
  input  logic                    rst,
  crs_bus_if.responder            bus,
  input  crs_pkg::crs_word_t      scratch_rd_data,
  input  crs_pkg::crs_word_t      vnum,
  output logic [6:0]              trig_ctrl,
  output crs_pkg::trig_thresh_t   trig_thresh,
  output logic                    trig_mode,
  output logic                    cnst_run,
  output logic [11:0]             cnst_conf,
  output logic [11:0]             test_conf,
  output logic [7:0]              post_conf,
  output logic [4:0]              pre_conf,
  output logic [num_channels-1:0] trig_run,
  output logic [num_channels-1:0] wvb_arm,
  output logic [num_channels-1:0] wvb_rst,
  input  logic [num_channels-1:0] wvb_armed,
  input  logic [num_channels-1:0] wvb_overflow,
  output crs_pkg::chan_sel_t      status_sel,
  input  crs_pkg::crs_word_t      n_wfms,
  input  crs_pkg::crs_word_t      wds_used,
  output crs_pkg::pg_addr_t       pg_req_addr,
  output logic                    pg_optype,
  output logic                    pg_start,
  output logic                    mem_en,
  input  logic                    pg_task_val,
  input  logic                    rdout_run,
  input  crs_pkg::crs_word_t      rdout_len_in,
  output logic                    rdout_busy
);

  // channels above the low word
  localparam int hi_w = num_channels - crs_pkg::CHAN_LO_W;
  localparam int lo_w = crs_pkg::CHAN_LO_W;

  logic               wr;
  logic               rdout_done;
  logic               rd_ram;
  crs_pkg::crs_word_t rdout_len;
  crs_pkg::crs_word_t rd_mux;
  crs_pkg::crs_word_t rd_q;

  assign wr = bus.stb && bus.we;

  //////////////////////////////////////////////////////////////////////
  // write decode
  always_ff @(posedge clk) begin
    if (rst) begin
      trig_ctrl   <= '0;
      trig_thresh <= '0;
      trig_mode   <= 1'b0;
      cnst_run    <= 1'b0;
      cnst_conf   <= '0;
      test_conf   <= '0;
      post_conf   <= '0;
      pre_conf    <= '0;
      trig_run    <= '0;
      wvb_arm     <= '0;
      wvb_rst     <= '0;
      status_sel  <= '0;
      pg_req_addr <= '0;
      pg_optype   <= 1'b0;
      pg_start    <= 1'b0;
      mem_en      <= 1'b0;
      rdout_done  <= 1'b0;
    end else begin
      // one-shots
      trig_run   <= '0;
      wvb_arm    <= '0;
      pg_start   <= 1'b0;
      rdout_done <= 1'b0;
      if (wr) begin
        case (bus.adr)
          crs_pkg::ADR_TRIG_CTRL:   trig_ctrl <= bus.wr_data[6:0];
          crs_pkg::ADR_TRIG_THR:    trig_thresh <= bus.wr_data[11:0];
          crs_pkg::ADR_TRIG_RUN_LO: trig_run[lo_w-1:0] <= bus.wr_data;
          crs_pkg::ADR_TRIG_MODE:   trig_mode <= bus.wr_data[0];
          crs_pkg::ADR_ARM_LO:      wvb_arm[lo_w-1:0] <= bus.wr_data;
          crs_pkg::ADR_CNST_RUN:    cnst_run <= bus.wr_data[0];
          crs_pkg::ADR_CNST_CONF:   cnst_conf <= bus.wr_data[11:0];
          crs_pkg::ADR_TEST_CONF:   test_conf <= bus.wr_data[11:0];
          crs_pkg::ADR_POST_CONF:   post_conf <= bus.wr_data[7:0];
          crs_pkg::ADR_PRE_CONF:    pre_conf <= bus.wr_data[4:0];
          crs_pkg::ADR_RDOUT_DONE:  rdout_done <= bus.wr_data[0];
          crs_pkg::ADR_WVB_RST_LO:  wvb_rst[lo_w-1:0] <= bus.wr_data;
          crs_pkg::ADR_STATUS_SEL:  status_sel <= bus.wr_data[4:0];
          crs_pkg::ADR_TRIG_RUN_HI: trig_run[num_channels-1:lo_w] <= bus.wr_data[hi_w-1:0];
          crs_pkg::ADR_ARM_HI:      wvb_arm[num_channels-1:lo_w] <= bus.wr_data[hi_w-1:0];
          crs_pkg::ADR_WVB_RST_HI:  wvb_rst[num_channels-1:lo_w] <= bus.wr_data[hi_w-1:0];
          crs_pkg::ADR_PG_ADDR_HI:  pg_req_addr[27:16] <= bus.wr_data[11:0];
          crs_pkg::ADR_PG_ADDR_LO:  pg_req_addr[15:0] <= bus.wr_data;
          crs_pkg::ADR_PG_OPTYPE:   pg_optype <= bus.wr_data[0];
          crs_pkg::ADR_PG_START:    pg_start <= bus.wr_data[0];
          crs_pkg::ADR_MEM_EN:      mem_en <= bus.wr_data[0];
          default: ;
        endcase
      end
    end
  end

  // readout busy tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      rdout_busy <= 1'b0;
      rdout_len  <= '0;
    end else if (rdout_run) begin
      rdout_busy <= 1'b1;
      rdout_len  <= rdout_len_in;
    end else if (rdout_done) begin
      rdout_busy <= 1'b0;
      rdout_len  <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read-back mux
  always_comb begin
    case (bus.adr)
      crs_pkg::ADR_VNUM:        rd_mux = vnum;
      crs_pkg::ADR_TRIG_CTRL:   rd_mux = crs_pkg::crs_word_t'(trig_ctrl);
      crs_pkg::ADR_TRIG_THR:    rd_mux = crs_pkg::crs_word_t'(trig_thresh);
      crs_pkg::ADR_TRIG_RUN_LO: rd_mux = trig_run[lo_w-1:0];
      crs_pkg::ADR_TRIG_MODE:   rd_mux = crs_pkg::crs_word_t'(trig_mode);
      crs_pkg::ADR_ARM_LO:      rd_mux = wvb_arm[lo_w-1:0];
      crs_pkg::ADR_ARMED_LO:    rd_mux = wvb_armed[lo_w-1:0];
      crs_pkg::ADR_CNST_RUN:    rd_mux = crs_pkg::crs_word_t'(cnst_run);
      crs_pkg::ADR_CNST_CONF:   rd_mux = crs_pkg::crs_word_t'(cnst_conf);
      crs_pkg::ADR_TEST_CONF:   rd_mux = crs_pkg::crs_word_t'(test_conf);
      crs_pkg::ADR_POST_CONF:   rd_mux = crs_pkg::crs_word_t'(post_conf);
      crs_pkg::ADR_PRE_CONF:    rd_mux = crs_pkg::crs_word_t'(pre_conf);
      crs_pkg::ADR_RDOUT_LEN:   rd_mux = rdout_len;
      crs_pkg::ADR_RDOUT_DONE:  rd_mux = crs_pkg::crs_word_t'(rdout_done);
      crs_pkg::ADR_N_WFMS:      rd_mux = n_wfms;
      crs_pkg::ADR_WDS_USED:    rd_mux = wds_used;
      crs_pkg::ADR_OVERFLOW_LO: rd_mux = wvb_overflow[lo_w-1:0];
      crs_pkg::ADR_WVB_RST_LO:  rd_mux = wvb_rst[lo_w-1:0];
      crs_pkg::ADR_STATUS_SEL:  rd_mux = crs_pkg::crs_word_t'(status_sel);
      crs_pkg::ADR_TRIG_RUN_HI: rd_mux = crs_pkg::crs_word_t'(trig_run[num_channels-1:lo_w]);
      crs_pkg::ADR_ARM_HI:      rd_mux = crs_pkg::crs_word_t'(wvb_arm[num_channels-1:lo_w]);
      crs_pkg::ADR_ARMED_HI:    rd_mux = crs_pkg::crs_word_t'(wvb_armed[num_channels-1:lo_w]);
      crs_pkg::ADR_OVERFLOW_HI: rd_mux = crs_pkg::crs_word_t'(wvb_overflow[num_channels-1:lo_w]);
      crs_pkg::ADR_WVB_RST_HI:  rd_mux = crs_pkg::crs_word_t'(wvb_rst[num_channels-1:lo_w]);
      crs_pkg::ADR_PG_ADDR_HI:  rd_mux = crs_pkg::crs_word_t'(pg_req_addr[27:16]);
      crs_pkg::ADR_PG_ADDR_LO:  rd_mux = pg_req_addr[15:0];
      crs_pkg::ADR_PG_OPTYPE:   rd_mux = crs_pkg::crs_word_t'(pg_optype);
      // busy until the acknowledge has cleared the request
      crs_pkg::ADR_PG_START:    rd_mux = crs_pkg::crs_word_t'(pg_task_val);
      crs_pkg::ADR_MEM_EN:      rd_mux = crs_pkg::crs_word_t'(mem_en);
      default:                  rd_mux = '0;
    endcase
  end

  // sampled on the strobe, held until the next one
  always_ff @(posedge clk) begin
    if (bus.stb) begin
      rd_q   <= rd_mux;
      rd_ram <= bus.adr < crs_pkg::SCRATCH_LIMIT;
    end
  end

  // RAM word is already registered on the same strobe
  assign bus.rd_data = rd_ram ? scratch_rd_data : rd_q;

endmodule

//--- src/chan_status_mux.sv
`timescale 1ns/1ps

module chan_status_mux #(
  parameter int num_channels = 24
) (
  input  logic                       clk,
  input  crs_pkg::chan_sel_t         sel,
  input  logic [num_channels*16-1:0] wfms_in_buf,
  input  logic [num_channels*16-1:0] buf_wds_used,
  output crs_pkg::crs_word_t         n_wfms,
  output crs_pkg::crs_word_t         wds_used
);

  always_ff @(posedge clk) begin
    if (sel < num_channels) begin
      n_wfms   <= wfms_in_buf[sel*16 +: 16];
      wds_used <= buf_wds_used[sel*16 +: 16];
    end else begin
      // no such channel
      n_wfms   <= '0;
      wds_used <= '0;
    end
  end

endmodule

//--- src/page_req_ctrl.sv
`timescale 1ns/1ps

module page_req_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic pg_start,
  input  logic mem_en,
  input  logic pg_ack,
  output logic pg_req,
  output logic pg_task_val
);

  // pg_ack comes from the memory controller's clock domain
  logic ack_meta;
  logic ack_s;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_meta <= 1'b0;
      ack_s    <= 1'b0;
    end else begin
      ack_meta <= pg_ack;
      ack_s    <= ack_meta;
    end
  end

  // request held until acked, dropped at once if memory is disabled
  always_ff @(posedge clk) begin
    if (rst) begin
      pg_req <= 1'b0;
    end else if (ack_s || !mem_en) begin
      pg_req <= 1'b0;
    end else if (pg_start) begin
      pg_req <= 1'b1;
    end
  end

  assign pg_task_val = pg_req || ack_s;

endmodule

//--- src/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram (
  input  logic               clk,
  crs_bus_if.responder       bus,
  output crs_pkg::crs_word_t rd_data
);

  crs_pkg::crs_word_t mem [2048];
  logic [10:0]        ram_adr;
  logic               ram_we;

  assign ram_adr = bus.adr[10:0];
  // register space above the RAM is left alone
  assign ram_we  = bus.stb && bus.we && (bus.adr < crs_pkg::SCRATCH_LIMIT);

  always_ff @(posedge clk) begin
    if (ram_we) begin
      mem[ram_adr] <= bus.wr_data;
    end
    if (bus.stb) begin
      rd_data <= mem[ram_adr];
    end
  end

endmodule

//--- src/xdom_crs.sv
`timescale 1ns/1ps

module xdom_crs #(
  parameter int num_channels = 24
) (
  input  logic                       clk,
  input  logic                       rst,
  // host port a
  input  logic                       a_req,
  input  logic                       a_we,
  input  crs_pkg::crs_adr_t          a_adr,
  input  crs_pkg::crs_word_t         a_wr_data,
  output logic                       a_ack,
  output crs_pkg::crs_word_t         a_rd_data,
  // host port b
  input  logic                       b_req,
  input  logic                       b_we,
  input  crs_pkg::crs_adr_t          b_adr,
  input  crs_pkg::crs_word_t         b_wr_data,
  output logic                       b_ack,
  output crs_pkg::crs_word_t         b_rd_data,
  input  crs_pkg::crs_word_t         vnum,
  // trigger and waveform buffer config
  output logic [6:0]                 trig_ctrl,
  output crs_pkg::trig_thresh_t      trig_thresh,
  output logic                       trig_mode,
  output logic                       cnst_run,
  output logic [11:0]                cnst_conf,
  output logic [11:0]                test_conf,
  output logic [7:0]                 post_conf,
  output logic [4:0]                 pre_conf,
  output logic [num_channels-1:0]    trig_run,
  output logic [num_channels-1:0]    wvb_arm,
  output logic [num_channels-1:0]    wvb_rst,
  // buffer status
  input  logic [num_channels-1:0]    wvb_armed,
  input  logic [num_channels-1:0]    wvb_overflow,
  input  logic [num_channels*16-1:0] wfms_in_buf,
  input  logic [num_channels*16-1:0] buf_wds_used,
  // readout
  input  logic                       rdout_run,
  input  crs_pkg::crs_word_t         rdout_len_in,
  output logic                       rdout_busy,
  // memory page requests
  output crs_pkg::pg_addr_t          pg_req_addr,
  output logic                       pg_optype,
  output logic                       pg_req,
  input  logic                       pg_ack,
  output logic                       mem_en
);

  crs_pkg::chan_sel_t status_sel;
  crs_pkg::crs_word_t n_wfms;
  crs_pkg::crs_word_t wds_used;
  crs_pkg::crs_word_t scratch_rd_data;
  logic               pg_start;
  logic               pg_task_val;

  crs_bus_if bus_i ();

  crs_arbiter arbiter_i (
    .*,
    .bus (bus_i)
  );

  crs_reg_file #(
    .num_channels (num_channels)
  ) reg_file_i (
    .*,
    .bus (bus_i)
  );

  chan_status_mux #(
    .num_channels (num_channels)
  ) status_mux_i (
    .*,
    .sel (status_sel)
  );

  page_req_ctrl page_req_i (
    .*
  );

  scratch_ram scratch_i (
    .clk     (clk),
    .bus     (bus_i),
    .rd_data (scratch_rd_data)
  );

endmodule

//--- dv/xdom_crs_checker.sv
`timescale 1ns/1ps

module xdom_crs_checker #(
  parameter int num_channels = 24
) (
  input logic                    clk,
  input logic [6:0]              trig_ctrl,
  input logic [11:0]             trig_thresh,
  input logic                    trig_mode,
  input logic                    cnst_run,
  input logic [11:0]             cnst_conf,
  input logic [11:0]             test_conf,
  input logic [7:0]              post_conf,
  input logic [4:0]              pre_conf,
  input logic [num_channels-1:0] trig_run,
  input logic [num_channels-1:0] wvb_arm,
  input logic [num_channels-1:0] wvb_rst,
  input logic [27:0]             pg_req_addr,
  input logic                    pg_optype,
  input logic                    pg_req,
  input logic                    mem_en,
  input logic                    rdout_busy,
  input logic                    a_ack,
  input logic [15:0]             a_rd_data,
  input logic                    b_ack,
  input logic [15:0]             b_rd_data
);

  int errors = 0;
  int tests = 0;
  int failed = 0;
  int test_errors = 0;
  int trig_cnt = 0;
  int arm_cnt = 0;
  logic [num_channels-1:0] trig_val;
  logic [num_channels-1:0] arm_val;
  logic [15:0]             a_seen;
  logic [15:0]             b_seen;

  // one-shot activity and response words seen while ack is high
  always @(posedge clk) begin
    if (trig_run != '0) begin
      trig_cnt = trig_cnt + 1;
      trig_val = trig_run;
    end
    if (wvb_arm != '0) begin
      arm_cnt = arm_cnt + 1;
      arm_val = wvb_arm;
    end
    if (a_ack) begin
      a_seen = a_rd_data;
    end
    if (b_ack) begin
      b_seen = b_rd_data;
    end
    // only one host is served at a time
    if (a_ack && b_ack) begin
      $display("both host ports were acknowledged at the same time");
      errors++;
      test_errors++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output port behind each register address
  function automatic logic [31:0] port_value(input logic [11:0] adr);
    case (adr)
      12'hffe: return 32'(trig_ctrl);
      12'hffd: return 32'(trig_thresh);
      12'hffb: return 32'(trig_mode);
      12'hff8: return 32'(cnst_run);
      12'hff7: return 32'(cnst_conf);
      12'hff6: return 32'(test_conf);
      12'hff5: return 32'(post_conf);
      12'hff4: return 32'(pre_conf);
      12'hef9: return 32'(wvb_rst[15:0]);
      12'hef0: return 32'(wvb_rst[num_channels-1:16]);
      12'hdff: return 32'(pg_req_addr[27:16]);
      12'hdfe: return 32'(pg_req_addr[15:0]);
      12'hdfd: return 32'(pg_optype);
      12'hdfc: return 32'(pg_req);
      12'hdfb: return 32'(mem_en);
      12'hefe: return 32'(rdout_busy);
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_read(input string name, input bit host, input logic [31:0] exp);
    check_value(name, exp, host ? 32'(b_seen) : 32'(a_seen));
  endtask

  task automatic check_port(input string name, input logic [11:0] adr, input logic [31:0] exp);
    check_value(name, exp, port_value(adr));
  endtask

  task automatic clear_pulses();
    trig_cnt = 0;
    arm_cnt  = 0;
    trig_val = '0;
    arm_val  = '0;
  endtask

  // TRIG_RUN_LO watches trig_run, anything else wvb_arm
  task automatic check_pulse(input string name, input logic [11:0] adr, input logic [31:0] exp);
    int          cnt;
    logic [31:0] val;
    cnt = (adr == 12'hffc) ? trig_cnt : arm_cnt;
    val = (adr == 12'hffc) ? 32'(trig_val) : 32'(arm_val);
    if (cnt != 1) begin
      $display("%s: one-shot output was active for %0d cycles instead of one", name, cnt);
      errors++;
      test_errors++;
    end
    check_value(name, exp, val);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (test_errors == 0) begin
      $display("passed %s", name);
    end else begin
      $display("failed %s", name);
      failed++;
    end
    test_errors = 0;
  endtask

endmodule

//--- dv/xdom_crs_tb.sv
`timescale 1ns/1ps

module xdom_crs_tb;

  localparam int NUM_CH = 24;
  localparam int MAX_STEPS = 64;
  localparam int ACK_TIMEOUT = 200;
  localparam int PG_TIMEOUT = 50;
  localparam logic [11:0] ADR_STATUS_SEL = 12'hef5;
  localparam logic [11:0] ADR_N_WFMS = 12'hefc;
  localparam logic [11:0] ADR_WDS_USED = 12'hefb;

  logic clk;
  logic rst;
  logic a_req, a_we, a_ack, b_req, b_we, b_ack;
  logic [11:0] a_adr, b_adr;
  logic [15:0] a_wr_data, a_rd_data, b_wr_data, b_rd_data;
  logic [15:0] vnum;
  logic [6:0] trig_ctrl;
  logic [11:0] trig_thresh, cnst_conf, test_conf;
  logic trig_mode, cnst_run;
  logic [7:0] post_conf;
  logic [4:0] pre_conf;
  logic [NUM_CH-1:0] trig_run, wvb_arm, wvb_rst, wvb_armed, wvb_overflow;
  logic [NUM_CH*16-1:0] wfms_in_buf, buf_wds_used;
  logic rdout_run, rdout_busy;
  logic [15:0] rdout_len_in;
  logic [27:0] pg_req_addr;
  logic pg_optype, pg_req, pg_ack, mem_en;

  // five words per step: op host adr data expected
  logic [31:0] vec [0:MAX_STEPS*5-1];
  logic [15:0] shadow [2048];

  xdom_crs #(.num_channels(NUM_CH)) dut_i (.*);

  xdom_crs_checker #(.num_channels(NUM_CH)) checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic string op_label(input logic [31:0] op);
    case (op)
      0: return "write";
      1: return "read";
      2: return "config";
      3: return "oneshot";
      4: return "scratch";
      5: return "status";
      6: return "dual";
      7: return "pg_ack";
      8: return "rdout_run";
      9: return "wait_pg";
      default: return "port";
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // host port handshake
  task automatic drive_host(input bit host, input bit req, input bit we,
                            input logic [11:0] adr, input logic [15:0] data);
    if (host) begin
      b_req = req;
      b_we = we;
      b_adr = adr;
      b_wr_data = data;
    end else begin
      a_req = req;
      a_we = we;
      a_adr = adr;
      a_wr_data = data;
    end
  endtask

  task automatic host_access(input bit host, input bit we, input logic [11:0] adr,
                             input logic [15:0] data, input int hold, input string name);
    int cnt;
    @(negedge clk);
    drive_host(host, 1'b1, we, adr, data);
    cnt = 0;
    while ((host ? b_ack : a_ack) !== 1'b1 && cnt < ACK_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= ACK_TIMEOUT) begin
      checker_i.note_failure(
        $sformatf("timeout in %s waiting for ack on host %0d", name, host));
    end
    // extra cycles with req held keep the other host waiting
    repeat (hold) @(negedge clk);
    drive_host(host, 1'b0, we, adr, data);
    cnt = 0;
    while ((host ? b_ack : a_ack) !== 1'b0 && cnt < ACK_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= ACK_TIMEOUT) begin
      checker_i.note_failure(
        $sformatf("timeout in %s waiting for ack to drop on host %0d", name, host));
    end
  endtask

  task automatic scratch_test(input int count, input string name);
    logic [10:0] adr_q [$];
    logic [10:0] adr;
    logic [15:0] data;
    for (int i = 0; i < count; i++) begin
      adr = 11'($urandom);
      data = 16'($urandom);
      shadow[adr] = data;
      adr_q.push_back(adr);
      host_access(1'b0, 1'b1, {1'b0, adr}, data, 0, name);
    end
    foreach (adr_q[i]) begin
      host_access(1'b1, 1'b0, {1'b0, adr_q[i]}, 16'h0, 0, name);
      checker_i.check_read(name, 1'b1, 32'(shadow[adr_q[i]]));
    end
  endtask

  task automatic status_sweep(input bit host, input string name);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      host_access(host, 1'b1, ADR_STATUS_SEL, 16'(ch), 0, name);
      host_access(host, 1'b0, ADR_N_WFMS, 16'h0, 0, name);
      checker_i.check_read(name, host, 32'(wfms_in_buf[ch*16 +: 16]));
      host_access(host, 1'b0, ADR_WDS_USED, 16'h0, 0, name);
      checker_i.check_read(name, host, 32'(buf_wds_used[ch*16 +: 16]));
    end
  endtask

  // both hosts at once, each reads back the other's word
  task automatic dual_host(input logic [11:0] adr, input logic [15:0] data, input string name);
    logic [15:0] inv;
    inv = ~data;
    fork
      host_access(1'b0, 1'b1, adr, data, 3, name);
      host_access(1'b1, 1'b1, adr + 12'd1, inv, 3, name);
    join
    fork
      host_access(1'b0, 1'b0, adr + 12'd1, 16'h0, 3, name);
      host_access(1'b1, 1'b0, adr, 16'h0, 3, name);
    join
    checker_i.check_read(name, 1'b0, 32'(inv));
    checker_i.check_read(name, 1'b1, 32'(data));
  endtask

  task automatic wait_pg_req(input bit level, input string name);
    int cnt;
    cnt = 0;
    while (pg_req !== level && cnt < PG_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= PG_TIMEOUT) begin
      checker_i.note_failure(
        $sformatf("timeout in %s waiting for pg_req to become %0d", name, level));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one vector step
  task automatic run_step(input int step);
    logic [31:0] op, host, adr, data, exp;
    string name;
    op = vec[step*5];
    host = vec[step*5+1];
    adr = vec[step*5+2];
    data = vec[step*5+3];
    exp = vec[step*5+4];
    name = $sformatf("%s_%03h_%0d", op_label(op), adr[11:0], step);
    case (op)
      0: host_access(host[0], 1'b1, adr[11:0], data[15:0], 0, name);
      1: begin
        host_access(host[0], 1'b0, adr[11:0], 16'h0, 0, name);
        checker_i.check_read(name, host[0], exp);
      end
      2: begin
        host_access(host[0], 1'b1, adr[11:0], data[15:0], 0, name);
        host_access(host[0], 1'b0, adr[11:0], 16'h0, 0, name);
        checker_i.check_read(name, host[0], exp);
        checker_i.check_port(name, adr[11:0], exp);
      end
      3: begin
        checker_i.clear_pulses();
        host_access(host[0], 1'b1, adr[11:0], data[15:0], 0, name);
        repeat (2) @(negedge clk);
        checker_i.check_pulse(name, adr[11:0], exp);
      end
      4: scratch_test(data, name);
      5: status_sweep(host[0], name);
      6: dual_host(adr[11:0], data[15:0], name);
      7: begin
        @(negedge clk);
        pg_ack = data[0];
      end
      8: begin
        @(negedge clk);
        rdout_len_in = data[15:0];
        rdout_run = 1'b1;
        @(negedge clk);
        rdout_run = 1'b0;
      end
      9: wait_pg_req(data[0], name);
      'ha: checker_i.check_port(name, adr[11:0], exp);
      default: checker_i.note_failure($sformatf("step %0d has unknown op code %h", step, op));
    endcase
    checker_i.end_test(name);
  endtask

  initial begin
    int seed_dummy;
    int step;
    seed_dummy = $urandom(32'h77c16e11);
    rst = 1'b1;
    drive_host(1'b0, 1'b0, 1'b0, 12'h0, 16'h0);
    drive_host(1'b1, 1'b0, 1'b0, 12'h0, 16'h0);
    vnum = 16'h3c21;
    wvb_armed = NUM_CH'($urandom);
    wvb_overflow = NUM_CH'($urandom);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      wfms_in_buf[ch*16 +: 16] = 16'($urandom);
      buf_wds_used[ch*16 +: 16] = 16'($urandom);
    end
    rdout_run = 1'b0;
    rdout_len_in = 16'h0;
    pg_ack = 1'b0;
    $readmemh("dv/xdom_crs_vectors.txt", vec);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (vec[0] === 32'bx) begin
      checker_i.note_failure("vector file dv/xdom_crs_vectors.txt could not be read");
    end else begin
      step = 0;
      while (step < MAX_STEPS && vec[step*5] !== 32'hff) begin
        run_step(step);
        step++;
      end
      if (step >= MAX_STEPS) begin
        checker_i.note_failure("vector file has no end marker");
      end
    end
    $display("tests %0d, failed %0d, errors %0d",
             checker_i.tests, checker_i.failed, checker_i.errors);
    if (checker_i.errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- dv/xdom_crs_vectors.txt
// one step per line, hex columns: op host adr data expected
// op 0 write, 1 read, 2 write/read/port, 3 one-shot, 4 scratch, 5 status sweep
// op 6 dual host, 7 pg_ack, 8 rdout_run pulse, 9 wait pg_req, a port check, ff end
1 0 fff 0000 3c21
2 0 ffe ffff 7f
2 1 ffd ffff fff
2 0 ffb ffff 1
2 1 ff8 ffff 1
2 0 ff7 ffff fff
2 1 ff6 ffff fff
2 0 ff5 ffff ff
2 1 ff4 ffff 1f
4 0 000 0010 0
1 1 e00 0000 0
1 0 ff3 0000 0
6 0 123 a5a5 0
3 0 ffc a5c3 a5c3
1 0 ffc 0000 0
3 1 ef3 005a 5a0000
1 1 ef3 0000 0
2 0 ef9 1234 1234
2 1 ef0 00a7 a7
5 0 000 0000 0
0 1 ef5 0018 0
1 1 efc 0000 0
1 1 efb 0000 0
2 0 dfb 0001 1
2 0 dff 0abc abc
2 1 dfe 1357 1357
2 0 dfd 0001 1
0 0 dfc 0001 0
9 0 000 0001 0
a 0 dfc 0000 1
1 1 dfc 0000 1
7 0 000 0001 0
9 0 000 0000 0
7 0 000 0000 0
1 0 dfc 0000 0
2 0 dfb 0000 0
0 1 dfc 0001 0
a 0 dfc 0000 0
1 1 dfc 0000 0
8 0 000 0456 0
1 0 eff 0000 456
a 0 efe 0000 1
0 1 efe 0001 0
1 1 eff 0000 0
a 0 efe 0000 0
ff 0 000 0000 0

//--- xdom_crs.f
src/crs_pkg.sv
src/crs_bus_if.sv
src/crs_arbiter.sv
src/crs_reg_file.sv
src/chan_status_mux.sv
src/page_req_ctrl.sv
src/scratch_ram.sv
src/xdom_crs.sv
dv/xdom_crs_checker.sv
dv/xdom_crs_tb.sv
